// ==== design/decodePkg.sv ====
/*
   Decode stage shared types and constants
   Word, register index and opcode types plus the opcodes and values the stage keys on
*/
package decodePkg;

   localparam int WORD_WIDTH   = 16;  // Datapath width of the whole processor
   localparam int REG_ADDR_W   = 3;   // Eight architectural registers
   localparam int OPCODE_WIDTH = 5;   // Major opcode sits in instruction bits 15 to 11

   // Data word, also used for PC values
   typedef logic [WORD_WIDTH-1:0]   wordT;

   // Index into the register file
   typedef logic [REG_ADDR_W-1:0]   regAddrT;

   typedef logic [OPCODE_WIDTH-1:0] opcodeT;  // Top five instruction bits

   // Jump-and-link forms, both of which write the return address into the link register
   localparam opcodeT OPC_JAL  = 5'b00110;  // Target from immediate
   localparam opcodeT OPC_JALR = 5'b00111;  // Target from register

   // Conditional branches all share these three top bits
   // Bits 12 to 11 then pick the condition
   localparam logic [2:0] BRANCH_CLASS = 3'b011;

   localparam regAddrT LINK_REG = 3'd7;  // R7 receives the return address

   // Instructions are counted so that the return address lies four past the current PC
   localparam wordT PC_STEP = 16'h0004;

endpackage

// ==== design/regReadIf.sv ====
/*
   Register read bundle
   Two read addresses out of decode control and the two words returned by the register file
*/
interface regReadIf;
   import decodePkg::*;

   regAddrT readAddr1;  // Rs, or R7 during a JAL
   regAddrT readAddr2;  // Always Rt
   wordT    readData1;
   wordT    readData2;

   // Control side picks the registers to read
   modport requester (output readAddr1, output readAddr2, input readData1, input readData2);

   // Register file answers combinationally
   modport regFile (input readAddr1, input readAddr2, output readData1, output readData2);

   modport monitor (input readData1, input readData2);  // Observers of the operands only

endinterface

// ==== design/decodeControl.sv ====
/*
   Decode control
   Splits the instruction, tracks jump-and-link down the pipe, steers read port 1
   and arbitrates the register write between link and writeback
*/
module decodeControl (
   input  logic              clk,
   input  logic              reset,
   input  decodePkg::wordT   instr,
   input  logic              en,            // Writeback stage wants to write
   input  decodePkg::regAddrT writeRegAddr, // Destination from writeback
   regReadIf.requester       readPort,
   output logic              jalNow,
   output logic              jalEx,
   output logic              linkSel,
   input  logic              link,          // External request for the link value
   output logic              writeEnable,
   output decodePkg::regAddrT writeAddr
);
   import decodePkg::*;

   opcodeT  opcode;
   regAddrT rsField;
   regAddrT rtField;
   logic    jalMem;  // JAL flag as it sits in memory
   logic    jalWb;   // JAL flag as it reaches writeback

   assign opcode  = instr[15:11];
   assign rsField = instr[10:8];
   assign rtField = instr[7:5];

   // Both jump-and-link forms write the return address right away in decode
   assign jalNow = (opcode == OPC_JAL) || (opcode == OPC_JALR);

   // Shadow of the JAL as it moves through ex, mem and wb
   always_ff @(posedge clk) begin
      if (reset) begin
         jalEx  <= 1'b0;
         jalMem <= 1'b0;
         jalWb  <= 1'b0;
      end else begin
         jalEx  <= jalNow;
         jalMem <= jalEx;
         jalWb  <= jalMem;
      end
   end

   // JAL with immediate reads R7 on port 1 so the old link value is visible
   assign readPort.readAddr1 = (opcode == OPC_JAL) ? LINK_REG : rsField;
   assign readPort.readAddr2 = rtField;  // Port 2 never redirects

   // Link address is selected while the JAL is in decode and for one cycle after
   assign linkSel = link || jalNow || jalEx;

   // The link write takes the port from whatever writeback presents
   assign writeAddr = jalNow ? LINK_REG : writeRegAddr;

   // The JAL already wrote R7 in decode, so its own writeback is dropped
   // A fresh JAL in decode still wins the port that cycle
   assign writeEnable = (en && !jalWb) || jalNow;

endmodule

// ==== design/registerFile.sv ====
/*
   Register file
   Eight 16-bit registers, two combinational read ports, one write port on the clock
*/
module registerFile (
   input  logic               clk,
   input  logic               reset,
   regReadIf.regFile          readPort,
   input  logic               writeEnable,
   input  decodePkg::regAddrT writeAddr,
   input  decodePkg::wordT    writeData
);
   import decodePkg::*;

   localparam int NUM_REGS = 2 ** REG_ADDR_W;

   wordT regs [NUM_REGS];  // R0 is an ordinary register here

   // A write lands at the edge, so a same-cycle read still sees the old word
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;  // Software expects a clean file after reset
         end
      end else if (writeEnable) begin
         regs[writeAddr] <= writeData;
      end
   end

   // No bypass from the write port
   assign readPort.readData1 = regs[readPort.readAddr1];
   assign readPort.readData2 = regs[readPort.readAddr2];

endmodule

// ==== design/linkWriteback.sv ====
/*
   Register write data select
   Chooses between the writeback result, a loaded immediate and the return address
*/
module linkWriteback (
   input  decodePkg::wordT pcNow,     // PC of the instruction now in decode
   input  decodePkg::wordT imm,       // Already extended by earlier logic
   input  decodePkg::wordT writeback,
   input  logic            lbi,       // Load-byte-immediate takes imm instead
   input  logic            linkSel,
   output decodePkg::wordT writeData
);
   import decodePkg::*;

   wordT linkAddr;
   wordT normalData;

   // Carry out of the top bit is simply lost
   assign linkAddr = pcNow + PC_STEP;

   assign normalData = lbi ? imm : writeback;

   // Return address has the last word whenever a link is in progress
   assign writeData = linkSel ? linkAddr : normalData;

endmodule

// ==== design/branchResolve.sv ====
/*
   Branch resolve
   Zero and sign tests on operand 1, then the taken decision driving the PC select
*/
module branchResolve (
   input  decodePkg::wordT instr,
   input  decodePkg::wordT operand,  // Rs value read on port 1
   input  logic            bFlag,    // Forces the instruction to count as a branch
   input  logic            jFlag,    // Taken regardless of condition
   input  logic            halt,
   output logic            pcSel
);
   import decodePkg::*;

   logic zeroFlag;
   logic signFlag;
   logic isBranch;
   logic condMet;

   assign zeroFlag = (operand == '0);
   assign signFlag = operand[WORD_WIDTH-1];  // Two's complement, so MSB set means negative

   assign isBranch = (instr[15:13] == BRANCH_CLASS) || bFlag;

   // Bits 12 to 11 choose one of the four compares against zero
   always_comb begin
      unique case (instr[12:11])
         2'b00:   condMet = zeroFlag;   // Equal zero
         2'b01:   condMet = !zeroFlag;  // Not zero
         2'b10:   condMet = signFlag;   // Less than zero
         default: condMet = !signFlag;  // Zero or above
      endcase
   end

   // Halt freezes the PC, so nothing is ever taken while it is up
   assign pcSel = isBranch && !halt && (condMet || jFlag);

endmodule

// ==== design/decodeStage.sv ====
/*
   Decode stage top
   Ties instruction control, register file, write data select and branch resolve together
*/
module decodeStage (
   input  logic               clk,
   input  logic               reset,
   input  logic               en,
   input  logic               lbi,
   input  logic               link,
   input  logic               bFlag,
   input  logic               jFlag,
   input  logic               halt,
   input  decodePkg::wordT    instr,
   input  decodePkg::wordT    imm,
   input  decodePkg::wordT    writeback,
   input  decodePkg::wordT    pcNow,
   input  decodePkg::regAddrT writeRegAddr,
   output decodePkg::wordT    reg1Data,
   output decodePkg::wordT    reg2Data,
   output logic               pcSel
);
   import decodePkg::*;

   regReadIf rdIf ();  // Read addresses and operands between control and the file

   logic    linkSel;
   logic    writeEnable;
   regAddrT writeAddr;
   wordT    writeData;

   // The JAL flags are only consumed through linkSel, so they stay unconnected here
   decodeControl u_decodeControl (
      .clk          (clk),
      .reset        (reset),
      .instr        (instr),
      .en           (en),
      .writeRegAddr (writeRegAddr),
      .readPort     (rdIf.requester),
      .jalNow       (),
      .jalEx        (),
      .linkSel      (linkSel),
      .link         (link),
      .writeEnable  (writeEnable),
      .writeAddr    (writeAddr)
   );

   registerFile u_registerFile (
      .clk         (clk),
      .reset       (reset),
      .readPort    (rdIf.regFile),
      .writeEnable (writeEnable),
      .writeAddr   (writeAddr),
      .writeData   (writeData)
   );

   linkWriteback u_linkWriteback (
      .pcNow     (pcNow),
      .imm       (imm),
      .writeback (writeback),
      .lbi       (lbi),
      .linkSel   (linkSel),
      .writeData (writeData)
   );

   branchResolve u_branchResolve (
      .instr   (instr),
      .operand (rdIf.readData1),  // Branches always test Rs
      .bFlag   (bFlag),
      .jFlag   (jFlag),
      .halt    (halt),
      .pcSel   (pcSel)
   );

   // Operands go straight out to execute in the same cycle
   assign reg1Data = rdIf.readData1;
   assign reg2Data = rdIf.readData2;

endmodule

// ==== test/decodeStageTb.sv ====
/*
   Decode stage testbench
   Directed tests of register reads and writes, link writes and branch resolve,
   checked against a shadow register model kept here
*/
module decodeStageTb;

   localparam int  CLK_HALF     = 10;   // 20-unit clock period
   localparam int  RESET_CYCLES = 5;
   localparam int  EDGE_TIMEOUT = 40;   // Time units allowed for one clock edge
   localparam time DRIVE_DELAY  = 2;    // Inputs move this long after the rising edge

   localparam logic [4:0] OPC_NOP    = 5'b00000;
   localparam logic [4:0] OPC_JAL    = 5'b00110;  // Jump-and-link, immediate target
   localparam logic [4:0] OPC_JALR   = 5'b00111;  // Jump-and-link, register target
   localparam logic [2:0] BRANCH_TOP = 3'b011;    // Conditional branch group
   localparam logic [2:0] OTHER_TOP  = 3'b101;    // Neither a branch nor a jump

   logic        clk = 1'b0;
   logic        reset;
   logic        en;
   logic        lbi;
   logic        link;
   logic        bFlag;
   logic        jFlag;
   logic        halt;
   logic [15:0] instr;
   logic [15:0] imm;
   logic [15:0] writeback;
   logic [15:0] pcNow;
   logic [2:0]  writeRegAddr;
   logic [15:0] reg1Data;
   logic [15:0] reg2Data;
   logic        pcSel;

   logic [15:0] shadow [8];  // Expected register contents
   logic        histEx;      // JAL seen one cycle ago
   logic        histMem;
   logic        histWb;      // JAL seen three cycles ago
   logic [15:0] lfsrState;
   int          cycleCount = 0;
   time         lastEdgeTime = 0;
   int          errorCount;
   int          checkCount;
   logic        timedOut;

   decodeStage u_decodeStage (
      .clk          (clk),
      .reset        (reset),
      .en           (en),
      .lbi          (lbi),
      .link         (link),
      .bFlag        (bFlag),
      .jFlag        (jFlag),
      .halt         (halt),
      .instr        (instr),
      .imm          (imm),
      .writeback    (writeback),
      .pcNow        (pcNow),
      .writeRegAddr (writeRegAddr),
      .reg1Data     (reg1Data),
      .reg2Data     (reg2Data),
      .pcSel        (pcSel)
   );

   always #CLK_HALF clk = ~clk;

   always @(posedge clk) begin
      cycleCount++;            // Lets the stimulus side poll for edges
      lastEdgeTime = $time;
   end

   // Galois LFSR, one step for every bit handed out
   function automatic logic [15:0] nextBits(int count);
      logic [15:0] result;
      result = '0;
      for (int i = 0; i < count; i++) begin
         if (lfsrState[0]) begin
            lfsrState = (lfsrState >> 1) ^ 16'hB400;
         end else begin
            lfsrState = lfsrState >> 1;
         end
         result = {result[14:0], lfsrState[0]};
      end
      return result;
   endfunction

   // Taken when in the branch group, not halted, and the condition or jFlag holds
   function automatic logic expectedPcSel(logic [15:0] ins, logic [15:0] op,
                                          logic b, logic j, logic h);
      logic branchGroup;
      logic condition;
      branchGroup = (ins[15:13] == BRANCH_TOP) || b;
      case (ins[12:11])
         2'd0:    condition = (op == 16'h0000);  // Zero
         2'd1:    condition = (op != 16'h0000);  // Not zero
         2'd2:    condition = op[15];            // Negative
         default: condition = !op[15];           // Not negative
      endcase
      return branchGroup && !h && (condition || j);
   endfunction

   task automatic checkValue(string name, logic [15:0] actual, logic [15:0] expected);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("FAIL %s: got 0x%h, expected 0x%h at time %0t",
                  name, actual, expected, $time);
      end
   endtask

   // Waits for the next rising edge, then lands DRIVE_DELAY after it
   task automatic nextCycle();
      int target;
      int waited;
      target = cycleCount + 1;
      waited = 0;
      while (!timedOut && cycleCount < target && waited < EDGE_TIMEOUT) begin
         #1;
         waited++;
      end
      if (!timedOut && cycleCount < target) begin
         $display("Timeout: no rising clock edge within %0d time units", EDGE_TIMEOUT);
         errorCount++;
         timedOut = 1'b1;  // Later waits return at once so the run can close
      end
      while ($time < lastEdgeTime + DRIVE_DELAY) begin
         #1;
      end
   endtask

   // One clock with the shadow model applying the write the current inputs ask for
   task automatic clockStep();
      logic        jalNowM;
      logic        doWrite;
      logic [2:0]  addr;
      logic [15:0] data;
      jalNowM = (instr[15:11] == OPC_JAL) || (instr[15:11] == OPC_JALR);
      doWrite = (en && !histWb) || jalNowM;  // Writeback of an old JAL is dropped
      addr    = jalNowM ? 3'd7 : writeRegAddr;
      if (link || jalNowM || histEx) begin
         data = pcNow + 16'd4;  // Return address
      end else begin
         data = lbi ? imm : writeback;
      end
      nextCycle();
      if (doWrite) begin
         shadow[addr] = data;
      end
      histWb  = histMem;
      histMem = histEx;
      histEx  = jalNowM;
   endtask

   task automatic idleInputs();
      en    = 1'b0;
      lbi   = 1'b0;
      link  = 1'b0;
      bFlag = 1'b0;
      jFlag = 1'b0;
      halt  = 1'b0;
   endtask

   task automatic setInstr(logic [4:0] opcode, logic [2:0] rs, logic [2:0] rt);
      logic [15:0] fill;
      fill  = nextBits(5);  // Low bits are don't-care for this stage
      instr = {opcode, rs, rt, fill[4:0]};
   endtask

   // Port 1 reads R7 under JAL, otherwise Rs
   task automatic checkReads(string tag);
      logic [2:0] port1;
      port1 = (instr[15:11] == OPC_JAL) ? 3'd7 : instr[10:8];
      #1;
      checkValue({tag, " reg1Data"}, reg1Data, shadow[port1]);
      checkValue({tag, " reg2Data"}, reg2Data, shadow[instr[7:5]]);
   endtask

   task automatic writeReg(logic [2:0] addr, logic [15:0] value);
      setInstr(OPC_NOP, addr, addr);
      en           = 1'b1;
      writeRegAddr = addr;
      writeback    = value;
      clockStep();
      en = 1'b0;
   endtask

   task automatic readsAfterReset();
      for (int r = 0; r < 8; r++) begin
         setInstr(OPC_NOP, 3'(r), 3'(7 - r));
         checkReads("reset");
         checkValue("reset reg1Data", reg1Data, 16'h0000);
         checkValue("reset reg2Data", reg2Data, 16'h0000);
         clockStep();
      end
   endtask

   task automatic writebackRoundTrip();
      logic [15:0] value;
      for (int r = 0; r < 8; r++) begin
         value = nextBits(16);
         setInstr(OPC_NOP, 3'(r), 3'(r));
         en           = 1'b1;
         writeRegAddr = 3'(r);
         writeback    = value;
         checkReads("same cycle");  // Old word until the edge
         clockStep();
         en        = 1'b0;
         writeback = ~value;
         checkReads("after write");
         checkValue("written reg1Data", reg1Data, value);
         checkValue("written reg2Data", reg2Data, value);
         clockStep();  // Write with en low must not land
         checkReads("en low");
         checkValue("en low reg1Data", reg1Data, value);
         clockStep();
      end
   endtask

   task automatic writeDataSources();
      logic [15:0] immVal;
      logic [15:0] pcVal;
      immVal = nextBits(16);
      setInstr(OPC_NOP, 3'd3, 3'd3);
      en           = 1'b1;
      lbi          = 1'b1;
      writeRegAddr = 3'd3;
      imm          = immVal;
      writeback    = nextBits(16);
      clockStep();
      en  = 1'b0;
      lbi = 1'b0;
      checkReads("lbi");
      checkValue("lbi stored reg1Data", reg1Data, immVal);
      clockStep();
      pcVal = nextBits(16);
      setInstr(OPC_NOP, 3'd5, 3'd5);
      en           = 1'b1;
      link         = 1'b1;
      writeRegAddr = 3'd5;
      pcNow        = pcVal;
      writeback    = nextBits(16);
      clockStep();
      en   = 1'b0;
      link = 1'b0;
      checkReads("link");
      checkValue("link stored reg2Data", reg2Data, pcVal + 16'd4);
      clockStep();
   endtask

   task automatic linkWriteCollision(logic [4:0] opcode, string tag);
      logic [15:0] pcVal;
      logic [15:0] oldR2;
      logic [15:0] d2;
      logic [15:0] d3;
      logic [15:0] d4;
      idleInputs();
      for (int i = 0; i < 3; i++) begin
         clockStep();  // Drain any earlier link flags
      end
      pcVal = nextBits(16);
      d2    = nextBits(16);
      d3    = nextBits(16);
      d4    = nextBits(16);
      oldR2 = shadow[2];
      setInstr(opcode, 3'd1, 3'd4);
      pcNow = pcVal;
      checkReads(tag);
      clockStep();  // Cycle N, the link write lands at its closing edge
      setInstr(OPC_NOP, 3'd7, 3'd7);
      checkReads({tag, " link"});
      checkValue({tag, " R7 reg1Data"}, reg1Data, pcVal + 16'd4);
      clockStep();  // N+1 idle
      en           = 1'b1;
      writeRegAddr = 3'd1;
      writeback    = d2;
      clockStep();  // N+2 lands
      writeRegAddr = 3'd2;
      writeback    = d3;
      clockStep();  // N+3 dropped, the slot of the JAL's own writeback
      writeRegAddr = 3'd3;
      writeback    = d4;
      clockStep();  // N+4 lands
      en = 1'b0;
      setInstr(OPC_NOP, 3'd1, 3'd2);
      checkReads({tag, " after"});
      checkValue({tag, " R1 reg1Data"}, reg1Data, d2);
      checkValue({tag, " R2 reg2Data"}, reg2Data, oldR2);
      clockStep();
      setInstr(OPC_NOP, 3'd3, 3'd7);
      checkReads({tag, " after"});
      checkValue({tag, " R3 reg1Data"}, reg1Data, d4);
      checkValue({tag, " R7 reg2Data"}, reg2Data, pcVal + 16'd4);
      clockStep();
   endtask

   task automatic branchConditions();
      logic [15:0] operand;
      logic [2:0]  top;
      logic [2:0]  flags;
      for (int kind = 0; kind < 3; kind++) begin
         case (kind)
            0:       operand = 16'h0000;
            1:       operand = nextBits(16) | 16'h8000;
            default: operand = (nextBits(16) & 16'h7FFF) | 16'h0001;
         endcase
         writeReg(3'd4, operand);  // Branches test Rs, here R4
         for (int cond = 0; cond < 4; cond++) begin
            for (int group = 0; group < 2; group++) begin
               top = (group == 0) ? BRANCH_TOP : OTHER_TOP;
               for (int f = 0; f < 8; f++) begin
                  flags = 3'(f);
                  setInstr({top, 2'(cond)}, 3'd4, 3'd0);
                  bFlag = flags[2];
                  jFlag = flags[1];
                  halt  = flags[0];
                  #1;
                  checkValue("branch reg1Data", reg1Data, operand);
                  checkValue($sformatf("pcSel top %b cond %0d flags %b", top, cond, flags),
                             {15'd0, pcSel},
                             {15'd0, expectedPcSel(instr, operand, bFlag, jFlag, halt)});
                  clockStep();
               end
            end
         end
      end
      idleInputs();
   endtask

   initial begin
      lfsrState  = 16'd51860;
      errorCount = 0;
      checkCount = 0;
      timedOut   = 1'b0;
      reset      = 1'b1;
      idleInputs();
      instr        = 16'h0000;
      imm          = 16'h0000;
      writeback    = 16'h0000;
      pcNow        = 16'h0000;
      writeRegAddr = 3'd0;
      for (int i = 0; i < 8; i++) begin
         shadow[i] = 16'h0000;  // Reset clears the whole file
      end
      histEx  = 1'b0;
      histMem = 1'b0;
      histWb  = 1'b0;
      for (int i = 0; i < RESET_CYCLES; i++) begin
         nextCycle();
      end
      reset = 1'b0;
      readsAfterReset();
      writebackRoundTrip();
      writeDataSources();
      linkWriteCollision(OPC_JAL, "jal");
      linkWriteCollision(OPC_JALR, "jalr");
      branchConditions();
      $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

// ==== decodeStage.f ====
design/decodePkg.sv
design/regReadIf.sv
design/decodeControl.sv
design/registerFile.sv
design/linkWriteback.sv
design/branchResolve.sv
design/decodeStage.sv
test/decodeStageTb.sv

// ==== run.sh ====
#!/bin/sh
# Build the decode stage testbench with Verilator, run it, then look for the pass line
verilator --binary --timing --top-module decodeStageTb -f decodeStage.f \
   -o decodeStageSim > build.log 2>&1 \
   && ./obj_dir/decodeStageSim > sim.log 2>&1 \
   || { echo "Build or simulation error, see build.log and sim.log"; exit 1; }
cat sim.log
grep -q "Simulation completed successfully" sim.log && exit 0 || exit 1
